//--- hw/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [xlen-1:0]       addr_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;
  typedef logic [xlen/8-1:0]     wmask_t;   // one bit per byte lane
  typedef logic [6:0]            opcode_t;
  typedef logic [2:0]            funct3_t;

  localparam addr_t reset_pc = 32'h8000_0000;

  // base opcodes, inst[6:0]
  localparam opcode_t op_imm    = 7'b001_0011;
  localparam opcode_t op_lui    = 7'b011_0111;
  localparam opcode_t op_auipc  = 7'b001_0111;
  localparam opcode_t op_jal    = 7'b110_1111;
  localparam opcode_t op_jalr   = 7'b110_0111;
  localparam opcode_t op_load   = 7'b000_0011;
  localparam opcode_t op_store  = 7'b010_0011;
  localparam opcode_t op_system = 7'b111_0011;

  // access size for loads and stores
  localparam funct3_t f3_byte   = 3'b000;
  localparam funct3_t f3_half   = 3'b001;
  localparam funct3_t f3_word   = 3'b010;
  localparam funct3_t f3_byte_u = 3'b100;
  localparam funct3_t f3_half_u = 3'b101;

  typedef enum logic {
    opa_rs1,
    opa_pc
  } opa_sel_t;

  typedef enum logic [1:0] {
    wb_sum,
    wb_link,   // pc + 4 of jal/jalr
    wb_load
  } wb_sel_t;

  typedef struct packed {
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    opa_sel_t opa_sel;
    wb_sel_t  wb_sel;
    logic     reg_wen;
    logic     is_load;
    logic     is_store;
    logic     is_jump;
    funct3_t  funct3;
    logic     is_ebreak;
    logic     illegal;
  } ctrl_t;

  typedef struct packed {
    addr_t  addr;    // word aligned
    word_t  wdata;
    wmask_t wmask;
    logic   write;
  } dmem_req_t;

  typedef enum logic {
    st_run,
    st_halt
  } core_state_t;

endpackage

`default_nettype wire

//--- hw/inst_decode.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode (
  input  rv_core_pkg::word_t inst,
  output rv_core_pkg::ctrl_t ctrl
);
  import rv_core_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_u;
  word_t   imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // immediate formats, sign taken from inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl         = '0;
    ctrl.rd      = inst[11:7];
    ctrl.rs1     = inst[19:15];
    ctrl.rs2     = inst[24:20];
    ctrl.funct3  = funct3;
    ctrl.opa_sel = opa_rs1;
    ctrl.wb_sel  = wb_sum;

    case (opcode)
      op_imm: begin
        ctrl.imm     = imm_i;
        ctrl.reg_wen = 1'b1;
        ctrl.illegal = (funct3 != 3'b000);  // only addi
      end
      op_lui: begin
        ctrl.rs1     = '0;  // x0 + imm
        ctrl.imm     = imm_u;
        ctrl.reg_wen = 1'b1;
      end
      op_auipc: begin
        ctrl.opa_sel = opa_pc;
        ctrl.imm     = imm_u;
        ctrl.reg_wen = 1'b1;
      end
      op_jal: begin
        ctrl.opa_sel = opa_pc;
        ctrl.imm     = imm_j;
        ctrl.wb_sel  = wb_link;
        ctrl.reg_wen = 1'b1;
        ctrl.is_jump = 1'b1;
      end
      op_jalr: begin
        ctrl.imm     = imm_i;
        ctrl.wb_sel  = wb_link;
        ctrl.reg_wen = 1'b1;
        ctrl.is_jump = 1'b1;
      end
      op_load: begin
        ctrl.imm     = imm_i;
        ctrl.wb_sel  = wb_load;
        ctrl.reg_wen = 1'b1;
        ctrl.is_load = 1'b1;
        // 011, 110 and 111 have no load
        ctrl.illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      op_store: begin
        ctrl.imm      = imm_s;
        ctrl.is_store = 1'b1;
        ctrl.illegal  = (funct3 > f3_word);
      end
      op_system: begin
        // ebreak is the only system instruction kept
        if (inst[31:20] == 12'h001 && inst[19:7] == '0) begin
          ctrl.is_ebreak = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      default: begin
        ctrl.illegal = 1'b1;
      end
    endcase

    // nothing of an illegal instruction may reach state
    if (ctrl.illegal) begin
      ctrl.reg_wen  = 1'b0;
      ctrl.is_load  = 1'b0;
      ctrl.is_store = 1'b0;
      ctrl.is_jump  = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic               clk,
  input  logic               rst_n,
  input  rv_core_pkg::ctrl_t ctrl,
  input  logic               wen,      // retire strobe
  input  rv_core_pkg::word_t rd_data,
  output rv_core_pkg::word_t rs1_data,
  output rv_core_pkg::word_t rs2_data
);
  import rv_core_pkg::*;

  word_t regs [1:2**reg_addr_w-1];  // x0 has no storage
  logic  do_write;

  assign do_write = wen & ctrl.reg_wen & (ctrl.rd != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (do_write) begin
      regs[ctrl.rd] <= rd_data;
    end
  end

  // async reads, x0 reads zero
  assign rs1_data = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
  assign rs2_data = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
  input  rv_core_pkg::ctrl_t ctrl,
  input  rv_core_pkg::addr_t pc,
  input  rv_core_pkg::word_t rs1_data,
  input  rv_core_pkg::word_t load_data,
  output rv_core_pkg::addr_t sum,
  output rv_core_pkg::word_t rd_data,
  output rv_core_pkg::addr_t next_pc
);
  import rv_core_pkg::*;

  word_t op_a;
  addr_t link;   // static next pc

  // one adder serves addi, lui, auipc, jump targets and load/store addresses
  always_comb begin
    case (ctrl.opa_sel)
      opa_pc:  op_a = pc;
      default: op_a = rs1_data;
    endcase
  end

  assign sum  = op_a + ctrl.imm;
  assign link = pc + 32'd4;

  // writeback select
  always_comb begin
    case (ctrl.wb_sel)
      wb_link: rd_data = link;
      wb_load: rd_data = load_data;
      default: rd_data = sum;
    endcase
  end

  // jal targets are already even, so clearing bit 0 only matters for jalr
  always_comb begin
    if (ctrl.is_jump) begin
      next_pc = {sum[xlen-1:1], 1'b0};
    end else begin
      next_pc = link;
    end
  end

endmodule

`default_nettype wire

//--- hw/load_store_unit.sv
`timescale 1ns/100ps
`default_nettype none

module load_store_unit (
  input  rv_core_pkg::ctrl_t     ctrl,
  input  logic                   run,
  input  rv_core_pkg::addr_t     sum,         // effective address
  input  rv_core_pkg::word_t     rs2_data,
  output logic                   dmem_valid,
  output rv_core_pkg::dmem_req_t dmem_req,
  input  logic                   dmem_ready,
  input  rv_core_pkg::word_t     dmem_rdata,
  output rv_core_pkg::word_t     load_data,
  output logic                   mem_done
);
  import rv_core_pkg::*;

  logic [1:0]  byte_off;
  word_t       store_data;
  wmask_t      store_mask;
  logic [7:0]  load_byte;
  logic [15:0] load_half;

  assign byte_off = sum[1:0];

  // store lanes, data is replicated so the mask alone picks the bytes
  always_comb begin
    case (ctrl.funct3)
      f3_byte: begin
        store_data = {4{rs2_data[7:0]}};
        store_mask = 4'b0001 << byte_off;
      end
      f3_half: begin
        store_data = {2{rs2_data[15:0]}};
        store_mask = byte_off[1] ? 4'b1100 : 4'b0011;
      end
      default: begin  // sw
        store_data = rs2_data;
        store_mask = 4'b1111;
      end
    endcase
  end

  // request is a pure function of the current instruction, so it holds
  // while ready is low
  assign dmem_req.addr  = {sum[xlen-1:2], 2'b00};
  assign dmem_req.wdata = store_data;
  assign dmem_req.wmask = ctrl.is_store ? store_mask : '0;
  assign dmem_req.write = ctrl.is_store;

  assign dmem_valid = run & (ctrl.is_load | ctrl.is_store);
  assign mem_done   = dmem_valid & dmem_ready;

  // pick the addressed byte
  always_comb begin
    case (byte_off)
      2'd0:    load_byte = dmem_rdata[7:0];
      2'd1:    load_byte = dmem_rdata[15:8];
      2'd2:    load_byte = dmem_rdata[23:16];
      default: load_byte = dmem_rdata[31:24];
    endcase
  end

  assign load_half = byte_off[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

  // sign or zero extension by funct3
  always_comb begin
    case (ctrl.funct3)
      f3_byte:   load_data = {{24{load_byte[7]}}, load_byte};
      f3_half:   load_data = {{16{load_half[15]}}, load_half};
      f3_byte_u: load_data = {24'h00_0000, load_byte};
      f3_half_u: load_data = {16'h0000, load_half};
      default:   load_data = dmem_rdata;   // lw
    endcase
  end

endmodule

`default_nettype wire

//--- hw/pc_control.sv
`timescale 1ns/100ps
`default_nettype none

module pc_control (
  input  logic               clk,
  input  logic               rst_n,
  input  rv_core_pkg::ctrl_t ctrl,
  input  rv_core_pkg::addr_t next_pc,
  input  logic               mem_done,
  output rv_core_pkg::addr_t pc,
  output logic               run,
  output logic               retire,
  output logic               halt,
  output logic               illegal
);
  import rv_core_pkg::*;

  core_state_t state;
  logic        stop;     // ebreak or illegal in this slot
  logic        mem_op;

  assign stop   = ctrl.is_ebreak | ctrl.illegal;
  assign mem_op = ctrl.is_load | ctrl.is_store;

  assign run  = (state == st_run);
  assign halt = (state == st_halt);

  // memory ops wait for the handshake, everything else retires at once
  assign retire = run & ~stop & (mem_op ? mem_done : 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_run;
      pc      <= reset_pc;
      illegal <= 1'b0;
    end else if (run) begin
      if (stop) begin
        state   <= st_halt;       // pc stays on the stopping instruction
        illegal <= ctrl.illegal;
      end else if (retire) begin
        pc <= next_pc;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_top (
  input  logic                   clk,
  input  logic                   rst_n,
  output rv_core_pkg::addr_t     pc,
  input  rv_core_pkg::word_t     inst,
  output logic                   dmem_valid,
  output rv_core_pkg::dmem_req_t dmem_req,
  input  logic                   dmem_ready,
  input  rv_core_pkg::word_t     dmem_rdata,
  output logic                   halt,
  output logic                   illegal
);
  import rv_core_pkg::*;

  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;
  word_t rd_data;
  word_t load_data;
  addr_t sum;
  addr_t next_pc;
  logic  mem_done;
  logic  retire;
  logic  run;

  inst_decode inst_decode_i (
    .inst (inst),
    .ctrl (ctrl)
  );

  // write enable is qualified with ctrl.reg_wen inside
  reg_file reg_file_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .wen      (retire),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_unit execute_unit_i (
    .ctrl      (ctrl),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .load_data (load_data),
    .sum       (sum),
    .rd_data   (rd_data),
    .next_pc   (next_pc)
  );

  load_store_unit load_store_unit_i (
    .ctrl       (ctrl),
    .run        (run),
    .sum        (sum),
    .rs2_data   (rs2_data),
    .dmem_valid (dmem_valid),
    .dmem_req   (dmem_req),
    .dmem_ready (dmem_ready),
    .dmem_rdata (dmem_rdata),
    .load_data  (load_data),
    .mem_done   (mem_done)
  );

  pc_control pc_control_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .next_pc  (next_pc),
    .mem_done (mem_done),
    .pc       (pc),
    .run      (run),
    .retire   (retire),
    .halt     (halt),
    .illegal  (illegal)
  );

endmodule

`default_nettype wire

//--- bench/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;
  import rv_core_pkg::*;

  localparam int timeout_cycles = 2000;
  // word offsets of the sections in the stim file
  localparam int prog1_base  = 'h10;
  localparam int prog2_base  = 'h30;
  localparam int data_base   = 'h38;
  localparam int store_base  = 'h40;
  localparam int trace_base  = 'h70;
  localparam int result1     = 5;   // final pc, halt, illegal
  localparam int result2     = 8;

  logic      clk;
  logic      rst_n;
  addr_t     pc;
  word_t     inst;
  logic      dmem_valid;
  dmem_req_t dmem_req;
  logic      dmem_ready;
  word_t     dmem_rdata;
  logic      halt;
  logic      illegal;

  word_t     stim [0:255];
  word_t     imem [0:63];
  word_t     dmem [0:63];
  int        store_idx;
  int        trace_idx;
  logic      trace_on;
  int        wait_left;    // ready-low cycles left for this request
  logic      prev_live;
  logic      prev_valid;
  logic      prev_ready;
  addr_t     prev_pc;
  dmem_req_t prev_req;

  rv_core_top rv_core_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .inst       (inst),
    .dmem_valid (dmem_valid),
    .dmem_req   (dmem_req),
    .dmem_ready (dmem_ready),
    .dmem_rdata (dmem_rdata),
    .halt       (halt),
    .illegal    (illegal)
  );

  // fetch outside the program window returns an illegal word
  assign inst       = (pc[31:8] == reset_pc[31:8]) ? imem[pc[7:2]] : '0;
  assign dmem_rdata = dmem[dmem_req.addr[7:2]];

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic load_memories(input int prog_base, input int prog_len);
    for (int i = 0; i < 64; i++) begin
      imem[i] = {i[24:0], 7'b000_0000};   // opcode 0 is illegal
      dmem[i] = 32'hd5c3_0000 | (i << 2);
    end
    for (int k = 0; k < prog_len; k++) begin
      imem[k] = stim[prog_base + k];
    end
    for (int k = 0; k < stim[2]; k++) begin
      dmem[k] = stim[data_base + k];
    end
  endtask

  task automatic complete_access();
    word_t lanes;
    int    e;
    lanes = {{8{dmem_req.wmask[3]}}, {8{dmem_req.wmask[2]}},
             {8{dmem_req.wmask[1]}}, {8{dmem_req.wmask[0]}}};
    e     = store_base + 3 * store_idx;
    if (dmem_req.write) begin
      if (store_idx >= stim[3]) begin
        $display("unexpected store to %h at %0t ns", dmem_req.addr, $time);
        stop_run();
      end
      check_value("dmem_req.addr", dmem_req.addr, stim[e]);
      check_value("dmem_req.wdata lanes", dmem_req.wdata & lanes, stim[e + 1]);
      check_value("dmem_req.wmask", dmem_req.wmask, stim[e + 2]);
      store_idx++;
      dmem[dmem_req.addr[7:2]] = (dmem[dmem_req.addr[7:2]] & ~lanes) | (dmem_req.wdata & lanes);
    end
  endtask

  // ready held low for a random number of cycles per request
  always @(posedge clk) begin
    #1;
    if (dmem_valid && wait_left == 0) begin
      dmem_ready = 1'b1;
    end else begin
      dmem_ready = 1'b0;
      if (dmem_valid) wait_left--;
    end
  end

  always @(negedge clk) begin : edge_monitor
    logic moved;
    moved = (pc !== prev_pc);
    if (rst_n && prev_live) begin
      // pc moves unless the core just halted or memory held it off
      check_value("pc moved", moved, !halt && (!prev_valid || prev_ready));
      if (prev_valid && !prev_ready) begin
        check_value("dmem_req.addr held", dmem_req.addr, prev_req.addr);
        check_value("dmem_req.wdata held", dmem_req.wdata, prev_req.wdata);
        check_value("dmem_req.wmask held", dmem_req.wmask, prev_req.wmask);
        check_value("dmem_req.write held", dmem_req.write, prev_req.write);
      end
      if (moved && trace_on) begin
        if (trace_idx >= stim[4]) begin
          $display("pc %h runs past the expected trace", pc);
          stop_run();
        end
        check_value("pc", pc, reset_pc + stim[trace_base + trace_idx]);
        trace_idx++;
      end
    end
    if (rst_n && dmem_valid && dmem_ready) begin  // handshake on the next edge
      complete_access();
      wait_left = $urandom % 4;
    end
    prev_live  = rst_n && !halt;
    prev_valid = dmem_valid;
    prev_ready = dmem_ready;
    prev_pc    = pc;
    prev_req   = dmem_req;
  end

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (!halt) begin
      if (cycles == timeout_cycles) begin
        $display("timeout: core did not halt within %0d cycles", timeout_cycles);
        stop_run();
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic run_program(input int prog_base, input int prog_len, input int res);
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    load_memories(prog_base, prog_len);
    trace_idx = 1;
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_value("pc after reset", pc, reset_pc);
    check_value("dmem_valid after reset", dmem_valid, 0);
    check_value("halt after reset", halt, 0);
    check_value("illegal after reset", illegal, 0);
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    wait_for_halt();
    check_value("pc at halt", pc, stim[res]);
    check_value("illegal", illegal, stim[res + 2]);
    repeat (4) @(negedge clk);   // halted core stays put
    check_value("pc after halt", pc, stim[res]);
    check_value("dmem_valid after halt", dmem_valid, 0);
    check_value("halt held", halt, stim[res + 1]);
  endtask

  initial begin
    rst_n      = 1'b0;
    dmem_ready = 1'b0;
    store_idx  = 0;
    trace_idx  = 1;
    trace_on   = 1'b1;
    prev_live  = 1'b0;
    prev_valid = 1'b0;
    prev_ready = 1'b0;
    prev_pc    = '0;
    prev_req   = '0;
    wait_left  = $urandom(92035) % 4;
    $readmemh("bench/core_stim.txt", stim);
    load_memories(prog1_base, stim[0]);

    run_program(prog1_base, stim[0], result1);
    check_value("store count", store_idx, stim[3]);
    check_value("pc trace length", trace_idx, stim[4]);

    // second program ends on an illegal opcode
    trace_on = 1'b0;
    run_program(prog2_base, stim[1], result2);

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hw/rv_core_pkg.sv
hw/inst_decode.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/load_store_unit.sv
hw/pc_control.sv
hw/rv_core_top.sv
bench/tb_rv_core.sv

//--- bench/core_stim.txt
// hex words for $readmemh; @00 counts: prog1, prog2, data words, stores, pc trace
// then final pc, halt, illegal per run; stores are addr, lane data, mask
// the trace lists pc offsets from reset_pc in the order they are reached
@00
1b 02 02 0c 19
80000068 1 0   // run 1 ends on ebreak
80000004 1 1   // run 2 ends on an illegal opcode
@10
00001537  // lui   x10, 0x1
ffb00093  // addi  x1, x0, -5
00152823  // sw    x1, 16(x10)
abcde137  // lui   x2, 0xabcde
12310113  // addi  x2, x2, 0x123
00252a23  // sw    x2, 20(x10)
00002197  // auipc x3, 0x2
00352c23  // sw    x3, 24(x10)
0080026f  // jal   x4, +8
00100073  // ebreak, skipped
00452e23  // sw    x4, 28(x10)
011202e7  // jalr  x5, 17(x4)
00100073  // ebreak, skipped
02552023  // sw    x5, 32(x10)
00050303  // lb    x6, 0(x10)
02652223  // sw    x6, 36(x10)
00354383  // lbu   x7, 3(x10)
02752423  // sw    x7, 40(x10)
00251403  // lh    x8, 2(x10)
02852623  // sw    x8, 44(x10)
00455483  // lhu   x9, 4(x10)
02952823  // sw    x9, 48(x10)
00452583  // lw    x11, 4(x10)
02b52a23  // sw    x11, 52(x10)
02251d23  // sh    x2, 58(x10)
02150ea3  // sb    x1, 61(x10)
00100073  // ebreak
@30
00100093  // addi  x1, x0, 1
00000033  // add, not supported
@38
876543f1  // 0x1000
12348abc  // 0x1004
@40
00001010 fffffffb f
00001014 abcde123 f
00001018 80002018 f
0000101c 80000024 f
00001020 80000030 f
00001024 fffffff1 f
00001028 00000087 f
0000102c ffff8765 f
00001030 00008abc f
00001034 12348abc f
00001038 e1230000 c
0000103c 0000fb00 2
@70
00 04 08 0c 10 14 18 1c 20 28 2c 34 38
3c 40 44 48 4c 50 54 58 5c 60 64 68
